/* common/dcache_pkg.sv */
// L1 data cache shared definitions
// widths, depths, load FSM encoding and address views
`default_nettype none

package dcache_pkg;

  localparam int unsigned XLEN       = 32;
  localparam int unsigned ADDR_W     = 32;
  localparam int unsigned BE_W       = XLEN / 8;
  localparam int unsigned INDEX_W    = 6;
  localparam int unsigned OFF_W      = 2;
  localparam int unsigned TAG_W      = ADDR_W - INDEX_W - OFF_W;
  localparam int unsigned NUM_LINES  = 1 << INDEX_W;
  localparam int unsigned WBUF_DEPTH = 4;
  localparam int unsigned WBUF_PTR_W = $clog2(WBUF_DEPTH);

  // load controller states
  localparam logic [1:0] LD_IDLE   = 2'd0;
  localparam logic [1:0] LD_LOOKUP = 2'd1;
  localparam logic [1:0] LD_MISS   = 2'd2;

  typedef struct packed {
    logic [TAG_W-1:0]   tag;
    logic [INDEX_W-1:0] index;
    logic [OFF_W-1:0]   offset;
  } paddr_fields_t;

  // raw address toward memory, split fields for the arrays
  typedef union packed {
    logic [ADDR_W-1:0] raw;
    paddr_fields_t     fields;
  } paddr_u;

  typedef struct packed {
    logic [ADDR_W-OFF_W-1:0] waddr;
    logic [XLEN-1:0]         data;
    logic [BE_W-1:0]         be;
  } wbuf_entry_t;

endpackage

`default_nettype wire

/* common/dcache_ifs.sv */
// L1 data cache internal interfaces
// array port, store update, memory read and memory write channels
`default_nettype none

// lookup and refill toward the arrays
interface cache_port_if;
  logic                          lookup_vld;
  logic [dcache_pkg::ADDR_W-1:0] addr;
  logic                          refill_we;
  logic [dcache_pkg::XLEN-1:0]   refill_data;
  logic                          hit;
  logic [dcache_pkg::XLEN-1:0]   rdata;

  modport master (output lookup_vld, addr, refill_we, refill_data, input hit, rdata);
  modport slave (input lookup_vld, addr, refill_we, refill_data, output hit, rdata);
endinterface

// byte-wise update of a cached word on a store hit
interface store_upd_if;
  logic                          upd_we;
  logic [dcache_pkg::ADDR_W-1:0] addr;
  logic [dcache_pkg::XLEN-1:0]   wdata;
  logic [dcache_pkg::BE_W-1:0]   be;

  modport master (output upd_we, addr, wdata, be);
  modport slave (input upd_we, addr, wdata, be);
endinterface

// load miss read, one outstanding
interface mem_rd_if;
  logic                          req;
  logic [dcache_pkg::ADDR_W-1:0] addr;
  logic                          ack;
  logic                          rvalid;
  logic [dcache_pkg::XLEN-1:0]   rdata;

  modport master (output req, addr, input ack, rvalid, rdata);
  modport slave (input req, addr, output ack, rvalid, rdata);
endinterface

// write buffer drain
interface mem_wr_if;
  logic                          req;
  logic [dcache_pkg::ADDR_W-1:0] addr;
  logic [dcache_pkg::XLEN-1:0]   wdata;
  logic [dcache_pkg::BE_W-1:0]   be;
  logic                          ack;

  modport master (output req, addr, wdata, be, input ack);
  modport slave (input req, addr, wdata, be, output ack);
endinterface

`default_nettype wire

/* design/dcache_mem.sv */
// L1 data cache arrays
// tag, data and valid storage with registered lookup, refill and store update
`default_nettype none

module dcache_mem (
  input  wire         clk_i,
  input  wire         rst_n_i,
  input  wire         flush_inv_i,
  cache_port_if.slave port_i,
  store_upd_if.slave  upd_i
);

  logic [dcache_pkg::TAG_W-1:0]     tag_q  [dcache_pkg::NUM_LINES];
  logic [dcache_pkg::XLEN-1:0]      data_q [dcache_pkg::NUM_LINES];
  logic [dcache_pkg::NUM_LINES-1:0] valid_q;

  dcache_pkg::paddr_u             lk_addr;
  dcache_pkg::paddr_u             up_addr;
  logic                           up_hit;
  logic [dcache_pkg::XLEN-1:0]    up_word;
  logic [dcache_pkg::XLEN-1:0]    lk_word;
  logic                           hit_q;
  logic [dcache_pkg::XLEN-1:0]    rdata_q;

  assign lk_addr.raw = port_i.addr;
  assign up_addr.raw = upd_i.addr;

  assign up_hit = upd_i.upd_we && valid_q[up_addr.fields.index]
                  && (tag_q[up_addr.fields.index] == up_addr.fields.tag);

  // store bytes merged over the cached word
  always_comb begin
    up_word = data_q[up_addr.fields.index];
    for (int b = 0; b < dcache_pkg::BE_W; b++) begin
      if (upd_i.be[b]) begin
        up_word[8*b +: 8] = upd_i.wdata[8*b +: 8];
      end
    end
  end

  // same-cycle store to the looked-up line is forwarded
  always_comb begin
    lk_word = data_q[lk_addr.fields.index];
    if (up_hit && (up_addr.fields.index == lk_addr.fields.index)) begin
      lk_word = up_word;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      hit_q   <= 1'b0;
      valid_q <= '0;
    end else begin
      hit_q <= port_i.lookup_vld && valid_q[lk_addr.fields.index]
               && (tag_q[lk_addr.fields.index] == lk_addr.fields.tag);
      if (flush_inv_i) begin
        valid_q <= '0;
      end else if (port_i.refill_we) begin
        valid_q[lk_addr.fields.index] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (port_i.lookup_vld) begin
      rdata_q <= lk_word;
    end
    if (port_i.refill_we) begin
      tag_q[lk_addr.fields.index]  <= lk_addr.fields.tag;
      data_q[lk_addr.fields.index] <= port_i.refill_data;
    end else if (up_hit) begin
      data_q[up_addr.fields.index] <= up_word;
    end
  end

  assign port_i.hit   = hit_q;
  assign port_i.rdata = rdata_q;

endmodule

`default_nettype wire

/* design/dcache_load_ctrl.sv */
// L1 data cache load controller
// accepts loads, returns hits after one cycle and refills on a miss
`default_nettype none

module dcache_load_ctrl (
  input  wire                            clk_i,
  input  wire                            rst_n_i,
  input  wire                            enable_i,
  input  wire                            ld_req_i,
  input  wire [dcache_pkg::ADDR_W-1:0]   ld_addr_i,
  output logic                           ld_gnt_o,
  output logic                           ld_rvalid_o,
  output logic [dcache_pkg::XLEN-1:0]    ld_rdata_o,
  output logic                           miss_o,
  cache_port_if.master                   port_o,
  mem_rd_if.master                       rd_o
);

  logic [1:0]                    state_q;
  logic [1:0]                    state_d;
  logic [dcache_pkg::ADDR_W-1:0] addr_q;
  logic                          acked_q;
  logic                          rvalid_q;
  logic [dcache_pkg::XLEN-1:0]   rdata_q;
  logic                          hit;
  logic                          accept;

  // disabled cache never hits
  assign hit    = (state_q == dcache_pkg::LD_LOOKUP) && port_o.hit && enable_i;
  assign miss_o = (state_q == dcache_pkg::LD_LOOKUP) && !hit;

  // next load may issue while a hit is shown
  assign ld_gnt_o    = (state_q == dcache_pkg::LD_IDLE) || hit;
  assign accept      = ld_req_i && ld_gnt_o;
  assign ld_rvalid_o = hit || rvalid_q;
  assign ld_rdata_o  = rvalid_q ? rdata_q : port_o.rdata;

  assign port_o.lookup_vld  = accept;
  assign port_o.addr        = (state_q == dcache_pkg::LD_MISS) ? addr_q : ld_addr_i;
  assign port_o.refill_we   = (state_q == dcache_pkg::LD_MISS) && rd_o.rvalid && enable_i;
  assign port_o.refill_data = rd_o.rdata;

  // request held from the miss cycle until ack
  assign rd_o.req  = miss_o || ((state_q == dcache_pkg::LD_MISS) && !acked_q);
  assign rd_o.addr = {addr_q[dcache_pkg::ADDR_W-1:dcache_pkg::OFF_W], {dcache_pkg::OFF_W{1'b0}}};

  always_comb begin
    state_d = state_q;
    case (state_q)
      dcache_pkg::LD_IDLE: begin
        if (accept) begin
          state_d = dcache_pkg::LD_LOOKUP;
        end
      end
      dcache_pkg::LD_LOOKUP: begin
        if (miss_o) begin
          state_d = dcache_pkg::LD_MISS;
        end else if (!accept) begin
          state_d = dcache_pkg::LD_IDLE;
        end
      end
      dcache_pkg::LD_MISS: begin
        if (rd_o.rvalid) begin
          state_d = dcache_pkg::LD_IDLE;
        end
      end
      default: state_d = dcache_pkg::LD_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q  <= dcache_pkg::LD_IDLE;
      acked_q  <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      state_q  <= state_d;
      rvalid_q <= rd_o.rvalid;
      if (rd_o.rvalid) begin
        acked_q <= 1'b0;
      end else if (rd_o.ack) begin
        acked_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      addr_q <= ld_addr_i;
    end
    if (rd_o.rvalid) begin
      rdata_q <= rd_o.rdata;
    end
  end

endmodule

`default_nettype wire

/* wbuffer/dcache_wbuffer.sv */
// L1 data cache write buffer
// store FIFO that updates hit words and drains in order to memory
`default_nettype none

module dcache_wbuffer (
  input  wire                            clk_i,
  input  wire                            rst_n_i,
  input  wire                            enable_i,
  input  wire                            st_block_i,
  input  wire                            st_req_i,
  input  wire [dcache_pkg::ADDR_W-1:0]   st_addr_i,
  input  wire [dcache_pkg::XLEN-1:0]     st_wdata_i,
  input  wire [dcache_pkg::BE_W-1:0]     st_be_i,
  output logic                           st_gnt_o,
  output logic                           wbuffer_empty_o,
  store_upd_if.master                    upd_o,
  mem_wr_if.master                       wr_o
);

  dcache_pkg::wbuf_entry_t           fifo_q [dcache_pkg::WBUF_DEPTH];
  dcache_pkg::wbuf_entry_t           head;
  logic [dcache_pkg::WBUF_PTR_W-1:0] wptr_q;
  logic [dcache_pkg::WBUF_PTR_W-1:0] rptr_q;
  logic [dcache_pkg::WBUF_PTR_W:0]   count_q;
  logic                              full;
  logic                              push;
  logic                              pop;

  ////////////////////////////////////////
  // store side

  assign full     = (count_q == (dcache_pkg::WBUF_PTR_W + 1)'(dcache_pkg::WBUF_DEPTH));
  assign st_gnt_o = !full && !st_block_i;
  assign push     = st_req_i && st_gnt_o;

  // cached copy follows the store at once
  assign upd_o.upd_we = push && enable_i;
  assign upd_o.addr   = st_addr_i;
  assign upd_o.wdata  = st_wdata_i;
  assign upd_o.be     = st_be_i;

  ////////////////////////////////////////
  // memory side

  assign wbuffer_empty_o = (count_q == '0);
  assign head            = fifo_q[rptr_q];
  assign pop             = wr_o.req && wr_o.ack;

  assign wr_o.req   = !wbuffer_empty_o;
  assign wr_o.addr  = {head.waddr, {dcache_pkg::OFF_W{1'b0}}};
  assign wr_o.wdata = head.data;
  assign wr_o.be    = head.be;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      count_q <= '0;
    end else begin
      if (push) begin
        wptr_q <= wptr_q + 1'b1;
      end
      if (pop) begin
        rptr_q <= rptr_q + 1'b1;
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // entry payload
  always_ff @(posedge clk_i) begin
    if (push) begin
      fifo_q[wptr_q] <= '{waddr: st_addr_i[dcache_pkg::ADDR_W-1:dcache_pkg::OFF_W],
                          data:  st_wdata_i,
                          be:    st_be_i};
    end
  end

endmodule

`default_nettype wire

/* design/dcache_missunit.sv */
// L1 data cache miss unit
// owns the memory port, orders buffer writes before load reads, sequences flush
`default_nettype none

module dcache_missunit (
  input  wire                            clk_i,
  input  wire                            rst_n_i,
  input  wire                            flush_i,
  output logic                           flush_ack_o,
  input  wire                            wbuffer_empty_i,
  output logic                           flush_inv_o,
  output logic                           st_block_o,
  mem_rd_if.slave                        rd_i,
  mem_wr_if.slave                        wr_i,
  output logic                           mem_req_o,
  output logic                           mem_we_o,
  output logic [dcache_pkg::ADDR_W-1:0]  mem_addr_o,
  output logic [dcache_pkg::XLEN-1:0]    mem_wdata_o,
  output logic [dcache_pkg::BE_W-1:0]    mem_be_o,
  input  wire                            mem_gnt_i,
  input  wire                            mem_rvalid_i,
  input  wire [dcache_pkg::XLEN-1:0]     mem_rdata_i
);

  logic rd_pend_q;
  logic rd_hold_q;
  logic flush_done_q;
  logic rd_sel;

  // read only once the buffer has drained, none started during a flush
  // rd_hold_q keeps a presented read stable until its grant
  assign rd_sel = rd_i.req && !rd_pend_q && wbuffer_empty_i && (!flush_i || rd_hold_q);

  ////////////////////////////////////////
  // memory port

  assign mem_req_o   = wr_i.req || rd_sel;
  assign mem_we_o    = wr_i.req;
  assign mem_addr_o  = wr_i.req ? wr_i.addr : rd_i.addr;
  assign mem_wdata_o = wr_i.req ? wr_i.wdata : '0;
  assign mem_be_o    = wr_i.req ? wr_i.be : '1;

  assign wr_i.ack    = wr_i.req && mem_gnt_i;
  assign rd_i.ack    = rd_sel && mem_gnt_i;
  assign rd_i.rvalid = rd_pend_q && mem_rvalid_i;
  assign rd_i.rdata  = mem_rdata_i;

  ////////////////////////////////////////
  // flush and store blocking

  assign flush_ack_o = flush_i && !flush_done_q && wbuffer_empty_i && !rd_pend_q && !rd_sel;
  assign flush_inv_o = flush_ack_o;

  // a requested read counts as outstanding so no store slips under the refill
  assign st_block_o = flush_i || rd_pend_q || rd_i.req;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rd_pend_q    <= 1'b0;
      rd_hold_q    <= 1'b0;
      flush_done_q <= 1'b0;
    end else begin
      if (rd_i.ack) begin
        rd_pend_q <= 1'b1;
      end else if (mem_rvalid_i) begin
        rd_pend_q <= 1'b0;
      end
      rd_hold_q    <= rd_sel && !mem_gnt_i;
      // one ack per flush request
      flush_done_q <= flush_i && (flush_done_q || flush_ack_o);
    end
  end

endmodule

`default_nettype wire

/* design/dcache_top.sv */
// L1 data cache top level
// write-through and direct-mapped, one load port and one store port
`default_nettype none

module dcache_top (
  input  wire                            clk_i,
  input  wire                            rst_n_i,
  input  wire                            enable_i,
  input  wire                            flush_i,
  output logic                           flush_ack_o,
  output logic                           miss_o,
  output logic                           wbuffer_empty_o,
  // load port
  input  wire                            ld_req_i,
  input  wire [dcache_pkg::ADDR_W-1:0]   ld_addr_i,
  output logic                           ld_gnt_o,
  output logic                           ld_rvalid_o,
  output logic [dcache_pkg::XLEN-1:0]    ld_rdata_o,
  // store port
  input  wire                            st_req_i,
  input  wire [dcache_pkg::ADDR_W-1:0]   st_addr_i,
  input  wire [dcache_pkg::XLEN-1:0]     st_wdata_i,
  input  wire [dcache_pkg::BE_W-1:0]     st_be_i,
  output logic                           st_gnt_o,
  // memory side
  output logic                           mem_req_o,
  output logic                           mem_we_o,
  output logic [dcache_pkg::ADDR_W-1:0]  mem_addr_o,
  output logic [dcache_pkg::XLEN-1:0]    mem_wdata_o,
  output logic [dcache_pkg::BE_W-1:0]    mem_be_o,
  input  wire                            mem_gnt_i,
  input  wire                            mem_rvalid_i,
  input  wire [dcache_pkg::XLEN-1:0]     mem_rdata_i
);

  logic flush_inv;
  logic st_block;

  cache_port_if cache_port ();
  store_upd_if  store_upd ();
  mem_rd_if     mem_rd ();
  mem_wr_if     mem_wr ();

  dcache_load_ctrl u_load_ctrl (
    .port_o (cache_port),
    .rd_o   (mem_rd),
    .*
  );

  dcache_wbuffer u_wbuffer (
    .st_block_i (st_block),
    .upd_o      (store_upd),
    .wr_o       (mem_wr),
    .*
  );

  dcache_mem u_mem (
    .flush_inv_i (flush_inv),
    .port_i      (cache_port),
    .upd_i       (store_upd),
    .*
  );

  dcache_missunit u_missunit (
    .wbuffer_empty_i (wbuffer_empty_o),
    .flush_inv_o     (flush_inv),
    .st_block_o      (st_block),
    .rd_i            (mem_rd),
    .wr_i            (mem_wr),
    .*
  );

endmodule

`default_nettype wire

/* verification/dcache_asserts.sv */
// L1 data cache protocol checks
// flush, memory request and load return rules, bound into the top level
`default_nettype none

module dcache_asserts (
  input wire        clk_i,
  input wire        rst_n_i,
  input wire        flush_ack_o,
  input wire        wbuffer_empty_o,
  input wire        ld_req_i,
  input wire        ld_gnt_o,
  input wire        ld_rvalid_o,
  input wire        mem_req_o,
  input wire        mem_we_o,
  input wire [31:0] mem_addr_o,
  input wire [31:0] mem_wdata_o,
  input wire [3:0]  mem_be_o,
  input wire        mem_gnt_i
);

  int unsigned fail_cnt = 0;
  logic [1:0]  ld_pend_q;

  // loads accepted and not yet returned
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ld_pend_q <= '0;
    end else begin
      ld_pend_q <= ld_pend_q + 2'(ld_req_i && ld_gnt_o) - 2'(ld_rvalid_o);
    end
  end

  flush_ack_empty: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    flush_ack_o |-> wbuffer_empty_o)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("flush_ack_o while the write buffer holds entries");
    end

  flush_ack_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    flush_ack_o |=> !flush_ack_o)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("flush_ack_o held longer than one cycle");
    end

  mem_req_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (mem_req_o && !mem_gnt_i) |=> (mem_req_o && $stable(mem_we_o) && $stable(mem_addr_o)
                                   && $stable(mem_wdata_o) && $stable(mem_be_o)))
    else begin
      fail_cnt = fail_cnt + 1;
      $error("memory request changed before its grant");
    end

  ld_rvalid_owed: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ld_rvalid_o |-> (ld_pend_q != 2'd0))
    else begin
      fail_cnt = fail_cnt + 1;
      $error("ld_rvalid_o without an accepted load");
    end

endmodule

bind dcache_top dcache_asserts u_asserts (.*);

`default_nettype wire

/* verification/dcache_tb.sv */
// L1 data cache testbench
// random memory model with a shadow copy, load, store, enable and flush checks
`default_nettype none

module dcache_tb;

  localparam int unsigned WAIT_LIMIT = 200;

  logic        clk_i;
  logic        rst_n_i;
  logic        enable_i;
  logic        flush_i;
  logic        flush_ack_o;
  logic        miss_o;
  logic        wbuffer_empty_o;
  logic        ld_req_i;
  logic [31:0] ld_addr_i;
  logic        ld_gnt_o;
  logic        ld_rvalid_o;
  logic [31:0] ld_rdata_o;
  logic        st_req_i;
  logic [31:0] st_addr_i;
  logic [31:0] st_wdata_i;
  logic [3:0]  st_be_i;
  logic        st_gnt_o;
  logic        mem_req_o;
  logic        mem_we_o;
  logic [31:0] mem_addr_o;
  logic [31:0] mem_wdata_o;
  logic [3:0]  mem_be_o;
  logic        mem_gnt_i;
  logic        mem_rvalid_i;
  logic [31:0] mem_rdata_i;

  // sparse word arrays, memory model and expected contents
  logic [31:0] model_mem [bit [29:0]];
  logic [31:0] shadow [bit [29:0]];
  int unsigned mem_reads;
  logic [23:0] tag_base;

  dcache_top dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  ////////////////////////////////////////
  // helpers

  // untouched words read as a pattern of their full address
  function automatic logic [31:0] fill_word(input logic [29:0] waddr);
    return {waddr, 2'b00} ^ 32'h9e37_79b9;
  endfunction

  function automatic logic [31:0] model_word(input logic [29:0] waddr);
    return model_mem.exists(waddr) ? model_mem[waddr] : fill_word(waddr);
  endfunction

  function automatic logic [31:0] shadow_word(input logic [29:0] waddr);
    return shadow.exists(waddr) ? shadow[waddr] : fill_word(waddr);
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] data,
                                              input logic [3:0] be);
    logic [31:0] word;
    word = old;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        word[8*b +: 8] = data[8*b +: 8];
      end
    end
    return word;
  endfunction

  function automatic logic [31:0] line_addr(input int unsigned idx);
    return {tag_base + 24'(idx / 64), 6'(idx), 2'b00};
  endfunction

  task automatic fail_stop(input string reason);
    $display("%s", reason);
    $display("test failed");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      fail_stop($sformatf("error: %s expected %h actual %h", name, exp, act));
    end
  endtask

  ////////////////////////////////////////
  // memory model

  initial begin : mem_model_proc
    logic        we_c;
    logic [31:0] addr_c;
    logic [31:0] wdata_c;
    logic [3:0]  be_c;
    mem_gnt_i    = 1'b0;
    mem_rvalid_i = 1'b0;
    mem_rdata_i  = '0;
    mem_reads    = 0;
    forever begin
      @(negedge clk_i);
      if (mem_req_o) begin
        repeat ($urandom_range(3, 0)) @(posedge clk_i);
        @(posedge clk_i);
        mem_gnt_i <= 1'b1;
        @(negedge clk_i);
        we_c    = mem_we_o;
        addr_c  = mem_addr_o;
        wdata_c = mem_wdata_o;
        be_c    = mem_be_o;
        @(posedge clk_i);
        mem_gnt_i <= 1'b0;
        if (we_c) begin
          model_mem[addr_c[31:2]] = merge_bytes(model_word(addr_c[31:2]), wdata_c, be_c);
        end else begin
          mem_reads++;
          // read data 1 to 3 cycles after the grant
          repeat ($urandom_range(2, 0)) @(posedge clk_i);
          mem_rvalid_i <= 1'b1;
          mem_rdata_i  <= model_word(addr_c[31:2]);
          @(posedge clk_i);
          mem_rvalid_i <= 1'b0;
        end
      end
    end
  end

  // bound protocol checks end the run at their first failure
  always @(negedge clk_i) begin
    if (dut.u_asserts.fail_cnt != 0) begin
      fail_stop("a bound protocol assertion failed");
    end
  end

  ////////////////////////////////////////
  // stimulus tasks

  task automatic do_load(input string name, input logic [31:0] addr, input bit expect_hit);
    int unsigned waited;
    int unsigned misses;
    int unsigned reads0;
    @(posedge clk_i);
    ld_req_i  <= 1'b1;
    ld_addr_i <= addr;
    waited = 0;
    do begin
      @(negedge clk_i);
      waited++;
      if (waited > WAIT_LIMIT) fail_stop($sformatf("timeout: %s load never granted", name));
    end while (!ld_gnt_o);
    @(posedge clk_i);
    ld_req_i <= 1'b0;
    reads0 = mem_reads;
    misses = 0;
    waited = 0;
    do begin
      @(negedge clk_i);
      waited++;
      if (miss_o) misses++;
      if (waited > WAIT_LIMIT) fail_stop($sformatf("timeout: %s load never returned", name));
    end while (!ld_rvalid_o);
    check_value({name, " data"}, shadow_word(addr[31:2]), ld_rdata_o);
    if (expect_hit) begin
      check_value({name, " hit latency"}, 32'd1, waited);
      check_value({name, " hit miss pulses"}, 32'd0, misses);
      check_value({name, " hit memory reads"}, 32'd0, mem_reads - reads0);
    end else begin
      check_value({name, " miss pulses"}, 32'd1, misses);
      check_value({name, " miss memory reads"}, 32'd1, mem_reads - reads0);
    end
  endtask

  task automatic do_store(input logic [31:0] addr, input logic [31:0] data, input logic [3:0] be);
    int unsigned waited;
    @(posedge clk_i);
    st_req_i   <= 1'b1;
    st_addr_i  <= addr;
    st_wdata_i <= data;
    st_be_i    <= be;
    waited = 0;
    do begin
      @(negedge clk_i);
      waited++;
      if (waited > WAIT_LIMIT) fail_stop("timeout: store was never granted");
    end while (!st_gnt_o);
    @(posedge clk_i);
    st_req_i <= 1'b0;
    shadow[addr[31:2]] = merge_bytes(shadow_word(addr[31:2]), data, be);
  endtask

  task automatic wait_drain();
    int unsigned waited;
    waited = 0;
    do begin
      @(negedge clk_i);
      waited++;
      if (waited > WAIT_LIMIT) fail_stop("timeout: write buffer never drained");
    end while (!wbuffer_empty_o);
  endtask

  task automatic do_flush();
    int unsigned waited;
    @(posedge clk_i);
    flush_i <= 1'b1;
    waited = 0;
    do begin
      @(negedge clk_i);
      waited++;
      if (waited > WAIT_LIMIT) fail_stop("timeout: flush was never acknowledged");
    end while (!flush_ack_o);
    check_value("flush buffer empty", 32'd1, wbuffer_empty_o);
    // request still held, no second ack
    repeat (3) begin
      @(negedge clk_i);
      check_value("flush single ack", 32'd0, flush_ack_o);
    end
    @(posedge clk_i);
    flush_i <= 1'b0;
  endtask

  ////////////////////////////////////////
  // test sequence

  initial begin
    void'($urandom(32'h05c8_134c));
    rst_n_i      = 1'b0;
    enable_i     = 1'b1;
    flush_i      = 1'b0;
    ld_req_i     = 1'b0;
    ld_addr_i    = '0;
    st_req_i     = 1'b0;
    st_addr_i    = '0;
    st_wdata_i   = '0;
    st_be_i      = '0;
    tag_base     = 24'($urandom);
    repeat (4) @(posedge clk_i);
    rst_n_i <= 1'b1;

    // first load misses, the repeat hits
    for (int i = 0; i < 8; i++) begin
      do_load("first_miss", line_addr(i), 1'b0);
      do_load("refill_hit", line_addr(i), 1'b1);
    end

    // write-through on cached lines
    for (int i = 0; i < 8; i++) begin
      do_store(line_addr(i), $urandom, 4'($urandom_range(15, 1)));
      do_load("write_through", line_addr(i), 1'b1);
      wait_drain();
      check_value("write_through memory", shadow_word(30'(line_addr(i) >> 2)),
                  model_word(30'(line_addr(i) >> 2)));
    end

    // loads right behind stores still in the buffer
    for (int i = 16; i < 20; i++) begin
      do_store(line_addr(i), $urandom, 4'($urandom_range(15, 1)));
      do_store(line_addr(i), $urandom, 4'($urandom_range(15, 1)));
      do_load("buffered_miss", line_addr(i), 1'b0);
      do_store(line_addr(i - 16), $urandom, 4'hf);
      do_load("buffered_hit", line_addr(i - 16), 1'b1);
    end

    // disabled cache never hits
    @(posedge clk_i);
    enable_i <= 1'b0;
    for (int n = 0; n < 2; n++) begin
      do_load("disabled_cached", line_addr(0), 1'b0);
      do_load("disabled_fresh", line_addr(40), 1'b0);
    end
    @(posedge clk_i);
    enable_i <= 1'b1;
    do_load("reenabled_hit", line_addr(1), 1'b1);

    // flush with a store still pending
    do_store(line_addr(2), $urandom, 4'($urandom_range(15, 1)));
    do_flush();
    do_load("flush_refetch", line_addr(0), 1'b0);
    do_load("flush_refetch", line_addr(2), 1'b0);
    do_load("flush_rehit", line_addr(2), 1'b1);

    wait_drain();
    repeat (4) @(posedge clk_i);
    if (dut.u_asserts.fail_cnt == 0) begin
      $display("test passed");
      $finish;
    end else begin
      fail_stop("bound protocol assertions reported errors");
    end
  end

endmodule

`default_nettype wire

/* vlog.f */
common/dcache_pkg.sv
common/dcache_ifs.sv
design/dcache_mem.sv
design/dcache_load_ctrl.sv
wbuffer/dcache_wbuffer.sv
design/dcache_missunit.sv
design/dcache_top.sv
verification/dcache_asserts.sv
verification/dcache_tb.sv
